/* src/smpc_pkg.sv */
package smpc_pkg;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} smpc_cmd_e;

	// Settle delays in CE cycles
	localparam logic [9:0] WAIT_CMD     = 10'd90;
	localparam logic [9:0] WAIT_POWER   = 10'd120;
	localparam logic [9:0] WAIT_CD      = 10'd159;
	localparam logic [9:0] WAIT_INTBACK = 10'd800;
	localparam logic [9:0] WAIT_SETTIME = 10'd279;
	localparam logic [9:0] WAIT_MISC    = 10'd127;

	// Host registers sit on odd byte addresses
	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	localparam int OREG_AW = 5;
	localparam logic [OREG_AW-1:0] OREG_COMREG_IDX = 5'd31;

	typedef struct packed {
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] b4;
		logic [7:0] b5;
		logic [7:0] b6;
	} smpc_ireg_t;

	typedef struct packed {
		logic [7:0]  sec;
		logic [7:0]  min;
		logic [7:0]  hour;
		logic [7:0]  days;
		logic [3:0]  day;    // Weekday
		logic [3:0]  month;  // Binary 1..12
		logic [15:0] year;
	} smpc_time_t;

	typedef struct packed {
		logic               valid;
		logic [OREG_AW-1:0] addr;
		logic [7:0]         data;
	} oreg_wr_t;

	typedef struct packed {
		logic               valid;
		logic [OREG_AW-1:0] addr;
	} oreg_rd_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sndres_n;
		logic cdres_n;
		logic mirq_n;
	} smpc_lines_t;

endpackage

/* src/smpc_host_regs.sv */
`timescale 1ns/1ps

module smpc_host_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic [5:0]           a,
	input  logic [7:0]           di,
	input  logic                 cs_n,
	input  logic                 rw_n,
	input  logic [7:0]           sr,
	input  logic                 sf_clr,
	input  logic [7:0]           rd_data,
	input  logic                 rd_done,
	output smpc_pkg::smpc_ireg_t ireg,
	output smpc_pkg::smpc_cmd_e  comreg,
	output logic                 cmd_start,
	output smpc_pkg::oreg_rd_t   rd_req,
	output logic [7:0]           do_q
);

	localparam int AW = smpc_pkg::OREG_AW;
	localparam logic [5:0] OREG_BASE = smpc_pkg::ADDR_OREG_FIRST[6:1];

	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_stb;
	logic       rd_stb;
	logic       in_oreg;
	logic       sf;
	logic [6:0] byte_addr;

	assign byte_addr = {a, 1'b1};
	assign wr_stb    = !rw_n && rw_n_old && !cs_n;  // Falling RW_N under CS_N
	assign rd_stb    = !cs_n && cs_n_old && rw_n;
	assign in_oreg   = byte_addr >= smpc_pkg::ADDR_OREG_FIRST &&
	                   byte_addr <= smpc_pkg::ADDR_OREG_LAST;

	assign rd_req.valid = rd_stb && in_oreg;
	assign rd_req.addr  = AW'(a - OREG_BASE);  // Word index into output regs

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old  <= 1'b1;
			cs_n_old  <= 1'b1;
			cmd_start <= 1'b0;
			sf        <= 1'b0;
		end else begin
			rw_n_old  <= rw_n;
			cs_n_old  <= cs_n;
			cmd_start <= wr_stb && byte_addr == smpc_pkg::ADDR_COMREG;
			if (sf_clr)
				sf <= 1'b0;
			if (wr_stb && byte_addr == smpc_pkg::ADDR_SF && di[0])
				sf <= 1'b1;  // Host write wins over clear
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_stb) begin
			case (byte_addr)
				smpc_pkg::ADDR_IREG0:          ireg.b0 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd2:   ireg.b1 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd4:   ireg.b2 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd6:   ireg.b3 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd8:   ireg.b4 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd10:  ireg.b5 <= di;
				smpc_pkg::ADDR_IREG0 + 7'd12:  ireg.b6 <= di;
				smpc_pkg::ADDR_COMREG:         comreg <= smpc_pkg::smpc_cmd_e'(di);
				default: ;
			endcase
		end
	end

	// Output register data lands one cycle after the status registers
	always_ff @(posedge CLK) begin
		if (rd_done)
			do_q <= rd_data;
		else if (rd_stb && !in_oreg) begin
			case (byte_addr)
				smpc_pkg::ADDR_SR: do_q <= sr;
				smpc_pkg::ADDR_SF: do_q <= {7'b0000000, sf};
				default:           do_q <= 8'h00;
			endcase
		end
	end

	a_rd_single: assert property (@(posedge CLK) disable iff (!RST_N)
		rd_req.valid |=> rd_done && !rd_req.valid);

endmodule

/* src/smpc_cmd_seq.sv */
`timescale 1ns/1ps

module smpc_cmd_seq (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  CE,
	input  logic                  MRES_N,
	input  logic                  TIME_SET,
	input  logic [3:0]            ac,
	input  logic                  cmd_start,
	input  smpc_pkg::smpc_cmd_e   comreg,
	input  smpc_pkg::smpc_ireg_t  ireg,
	input  smpc_pkg::smpc_time_t  now,
	input  logic                  wr_grant,
	output smpc_pkg::oreg_wr_t    wr_req,
	output logic                  time_load,
	output logic                  sf_clr,
	output logic [7:0]            sr,
	output smpc_pkg::smpc_lines_t lines
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_COMMAND,
		ST_EXEC,
		ST_INTBACK_DUMP,
		ST_END
	} state_e;

	localparam logic [smpc_pkg::OREG_AW-1:0] LAST_STATUS_SLOT = 5'd15;

	state_e                      state;
	state_e                      next_st;
	logic [9:0]                  wait_cnt;
	logic [smpc_pkg::OREG_AW-1:0] oreg_cnt;
	logic                        cmd_pend;
	logic                        resd;
	logic                        ste;
	logic                        stall;
	logic                        intback_ok;
	logic                        step;
	logic [7:0]                  dump_data;

	assign stall      = wr_req.valid && !wr_grant;  // Host read holds us one cycle
	assign step       = CE && !stall && MRES_N;
	assign intback_ok = ireg.b0[0] && ireg.b2 == 8'hF0;
	assign time_load  = step && state == ST_EXEC && comreg == smpc_pkg::CMD_SETTIME;
	assign sf_clr     = step && state == ST_END;

	always_comb begin
		case (oreg_cnt)
			5'd0:                      dump_data = {ste, resd, 6'b000000};
			5'd1:                      dump_data = now.year[15:8];
			5'd2:                      dump_data = now.year[7:0];
			5'd3:                      dump_data = {now.day, now.month};
			5'd4:                      dump_data = now.days;
			5'd5:                      dump_data = now.hour;
			5'd6:                      dump_data = now.min;
			5'd7:                      dump_data = now.sec;
			5'd9:                      dump_data = {4'b0000, ac};
			5'd10:                     dump_data = {1'b0, ~lines};  // Active-high line state
			smpc_pkg::OREG_COMREG_IDX: dump_data = comreg;
			default:                   dump_data = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state        <= ST_IDLE;
			next_st      <= ST_IDLE;
			wait_cnt     <= '0;
			oreg_cnt     <= '0;
			cmd_pend     <= 1'b0;
			resd         <= 1'b1;
			ste          <= 1'b0;
			sr           <= 8'h00;
			wr_req       <= '0;
			lines        <= '0;
			lines.mirq_n <= 1'b1;
		end else begin
			if (wr_grant)
				wr_req.valid <= 1'b0;
			if (!MRES_N) begin
				lines <= '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
				           sndres_n: 1'b0, cdres_n: 1'b1, mirq_n: 1'b1};
				sr    <= 8'h00;
				resd  <= 1'b1;
				ste   <= TIME_SET;
				state <= ST_IDLE;
			end else if (step) begin
				case (state)
					ST_IDLE: begin
						lines.mirq_n <= 1'b1;
						if (cmd_pend) begin
							cmd_pend <= 1'b0;
							wait_cnt <= smpc_pkg::WAIT_CMD;
							next_st  <= ST_COMMAND;
							state    <= ST_WAIT;
						end
					end
					ST_WAIT: begin
						if (wait_cnt != 10'd0)
							wait_cnt <= wait_cnt - 10'd1;
						else
							state <= next_st;
					end
					ST_COMMAND: begin
						oreg_cnt <= '0;
						next_st  <= ST_EXEC;
						state    <= ST_WAIT;
						case (comreg)
							smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON, smpc_pkg::CMD_SSHOFF,
							smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF:
								wait_cnt <= smpc_pkg::WAIT_POWER;
							smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF:
								wait_cnt <= smpc_pkg::WAIT_CD;
							smpc_pkg::CMD_SETTIME:
								wait_cnt <= smpc_pkg::WAIT_SETTIME;
							smpc_pkg::CMD_NMIREQ, smpc_pkg::CMD_RESENAB, smpc_pkg::CMD_RESDISA:
								wait_cnt <= smpc_pkg::WAIT_MISC;
							smpc_pkg::CMD_INTBACK: begin
								if (intback_ok) begin
									wait_cnt <= smpc_pkg::WAIT_INTBACK;
									next_st  <= ST_INTBACK_DUMP;
								end else
									state <= ST_END;  // Nothing written
							end
							default: state <= ST_END;
						endcase
					end
					ST_EXEC: begin
						wr_req <= '{valid: 1'b1, addr: smpc_pkg::OREG_COMREG_IDX, data: comreg};
						state  <= ST_END;
						case (comreg)
							smpc_pkg::CMD_MSHON: begin
								lines.mshres_n <= 1'b1;
								lines.mshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHON: begin
								lines.sshres_n <= 1'b1;
								lines.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHOFF: begin
								lines.sshres_n <= 1'b0;
								lines.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SNDON:   lines.sndres_n <= 1'b1;
							smpc_pkg::CMD_SNDOFF:  lines.sndres_n <= 1'b0;
							smpc_pkg::CMD_CDON:    lines.cdres_n <= 1'b1;
							smpc_pkg::CMD_CDOFF:   lines.cdres_n <= 1'b0;
							smpc_pkg::CMD_SETTIME: ste <= 1'b1;
							smpc_pkg::CMD_NMIREQ:  lines.mshnmi_n <= 1'b0;  // Released in end
							smpc_pkg::CMD_RESENAB: resd <= 1'b0;
							smpc_pkg::CMD_RESDISA: resd <= 1'b1;
							default: ;
						endcase
					end
					ST_INTBACK_DUMP: begin
						wr_req <= '{valid: 1'b1, addr: oreg_cnt, data: dump_data};
						if (oreg_cnt == smpc_pkg::OREG_COMREG_IDX) begin
							sr           <= 8'h4F;
							lines.mirq_n <= 1'b0;
							state        <= ST_END;
						end else if (oreg_cnt == LAST_STATUS_SLOT)
							oreg_cnt <= smpc_pkg::OREG_COMREG_IDX;
						else
							oreg_cnt <= oreg_cnt + 1'b1;
					end
					ST_END: begin
						if (comreg == smpc_pkg::CMD_NMIREQ)
							lines.mshnmi_n <= 1'b1;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
			if (cmd_start)
				cmd_pend <= 1'b1;
		end
	end

	a_state_legal: assert property (@(posedge CLK) disable iff (!RST_N)
		state inside {ST_IDLE, ST_WAIT, ST_COMMAND, ST_EXEC, ST_INTBACK_DUMP, ST_END});

	a_wr_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		wr_req.valid && !wr_grant |=> $stable(wr_req));

endmodule

/* src/smpc_rtc.sv */
`timescale 1ns/1ps

module smpc_rtc #(
	parameter int SEC_DIV = 4000000
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 CE,
	input  logic                 time_load,
	input  smpc_pkg::smpc_ireg_t ireg,
	output smpc_pkg::smpc_time_t now
);

	localparam int DW = $clog2(SEC_DIV);

	logic [DW-1:0] div_cnt;
	logic          sec_tick;
	logic          min_c;
	logic          hour_c;
	logic          day_c;
	logic          month_c;
	logic          year_c;
	logic [7:0]    month_last;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		return (v[3:0] == 4'd9) ? {v[7:4] + 4'd1, 4'd0} : v + 8'd1;
	endfunction

	always_comb begin
		case (now.month)
			4'd2:                      month_last = 8'h28;  // No leap years
			4'd4, 4'd6, 4'd9, 4'd11:   month_last = 8'h30;
			default:                   month_last = 8'h31;
		endcase
	end

	assign sec_tick = CE && div_cnt == DW'(SEC_DIV - 1);
	assign min_c    = sec_tick && now.sec == 8'h59;
	assign hour_c   = min_c && now.min == 8'h59;
	assign day_c    = hour_c && now.hour == 8'h23;
	assign month_c  = day_c && now.days == month_last;
	assign year_c   = month_c && now.month == 4'd12;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			now     <= '{sec: 8'h00, min: 8'h00, hour: 8'h00, days: 8'h01,
			             day: 4'd0, month: 4'd1, year: 16'h2024};
		end else if (time_load) begin
			now <= '{sec: ireg.b6, min: ireg.b5, hour: ireg.b4, days: ireg.b3,
			         day: ireg.b2[7:4], month: ireg.b2[3:0], year: {ireg.b0, ireg.b1}};
		end else if (CE) begin
			div_cnt <= sec_tick ? '0 : div_cnt + 1'b1;
			if (sec_tick)
				now.sec <= min_c ? 8'h00 : bcd_inc(now.sec);
			if (min_c)
				now.min <= hour_c ? 8'h00 : bcd_inc(now.min);
			if (hour_c)
				now.hour <= day_c ? 8'h00 : bcd_inc(now.hour);
			if (day_c) begin
				now.days <= month_c ? 8'h01 : bcd_inc(now.days);
				now.day  <= (now.day == 4'd6) ? 4'd0 : now.day + 4'd1;
			end
			if (month_c)
				now.month <= year_c ? 4'd1 : now.month + 4'd1;
			if (year_c) begin
				if (now.year[7:0] == 8'h99)
					now.year <= {bcd_inc(now.year[15:8]), 8'h00};
				else
					now.year[7:0] <= bcd_inc(now.year[7:0]);
			end
		end
	end

	a_sec_bcd: assert property (@(posedge CLK) disable iff (!RST_N)
		now.sec[3:0] <= 4'd9 && now.sec < 8'h60);

endmodule

/* src/smpc_oreg_arb.sv */
`timescale 1ns/1ps

module smpc_oreg_arb (
	input  logic               CLK,
	input  logic               RST_N,
	input  smpc_pkg::oreg_rd_t rd_req,
	input  smpc_pkg::oreg_wr_t wr_req,
	output logic [7:0]         rd_data,
	output logic               rd_done,
	output logic               wr_grant
);

	localparam int AW = smpc_pkg::OREG_AW;

	logic [7:0]    mem [2**AW];
	logic [AW-1:0] port_addr;

	// Host read has priority over the write
	assign wr_grant  = wr_req.valid && !rd_req.valid;
	assign port_addr = rd_req.valid ? rd_req.addr : wr_req.addr;

	always_ff @(posedge CLK) begin
		if (rd_req.valid)
			rd_data <= mem[port_addr];
		else if (wr_grant)
			mem[port_addr] <= wr_req.data;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			rd_done <= 1'b0;
		else
			rd_done <= rd_req.valid;
	end

	// A write blocked by a read goes through on the next cycle
	a_one_port: assert property (@(posedge CLK) disable iff (!RST_N)
		wr_req.valid && rd_req.valid |=> wr_grant);

endmodule

/* src/smpc_top.sv */
`timescale 1ns/1ps

module smpc_top #(
	parameter int SEC_DIV = 4000000
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  CE,
	input  logic                  MRES_N,
	input  logic                  TIME_SET,
	input  logic [3:0]            ac,
	input  logic [5:0]            a,
	input  logic [7:0]            di,
	input  logic                  cs_n,
	input  logic                  rw_n,
	output logic [7:0]            do_q,
	output smpc_pkg::smpc_lines_t lines
);

	smpc_pkg::smpc_ireg_t ireg;
	smpc_pkg::smpc_cmd_e  comreg;
	smpc_pkg::smpc_time_t now;
	smpc_pkg::oreg_rd_t   rd_req;
	smpc_pkg::oreg_wr_t   wr_req;
	logic                 cmd_start;
	logic                 sf_clr;
	logic                 time_load;
	logic                 rd_done;
	logic                 wr_grant;
	logic [7:0]           rd_data;
	logic [7:0]           sr;

	smpc_host_regs u_host (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n),
		.sr(sr), .sf_clr(sf_clr), .rd_data(rd_data), .rd_done(rd_done),
		.ireg(ireg), .comreg(comreg), .cmd_start(cmd_start), .rd_req(rd_req), .do_q(do_q)
	);

	smpc_cmd_seq u_seq (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .MRES_N(MRES_N), .TIME_SET(TIME_SET),
		.ac(ac), .cmd_start(cmd_start), .comreg(comreg), .ireg(ireg), .now(now),
		.wr_grant(wr_grant), .wr_req(wr_req), .time_load(time_load), .sf_clr(sf_clr),
		.sr(sr), .lines(lines)
	);

	smpc_rtc #(.SEC_DIV(SEC_DIV)) u_rtc (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .time_load(time_load), .ireg(ireg), .now(now)
	);

	smpc_oreg_arb u_arb (
		.CLK(CLK), .RST_N(RST_N), .rd_req(rd_req), .wr_req(wr_req),
		.rd_data(rd_data), .rd_done(rd_done), .wr_grant(wr_grant)
	);

endmodule

/* dv/smpc_tb_tasks.svh */
`ifndef SMPC_TB_TASKS_SVH
`define SMPC_TB_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic        fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		v    = {v[30:0], fb};
	end
	return v;
endfunction

function automatic logic [7:0] to_bcd(input int n);
	return 8'((n / 10) * 16 + n % 10);
endfunction

function automatic int bcd_to_int(input logic [7:0] v);
	return int'(v[7:4]) * 10 + int'(v[3:0]);
endfunction

// Write strobe is the falling RW_N seen under CS_N
task automatic bus_write(input logic [6:0] addr, input logic [7:0] data);
	@(posedge CLK);
	#5;
	a    = addr[6:1];
	di   = data;
	cs_n = 1'b0;
	rw_n = 1'b0;
	@(posedge CLK);
	#5;
	cs_n = 1'b1;
	rw_n = 1'b1;
endtask

task automatic bus_read(input logic [6:0] addr, output logic [7:0] data);
	@(posedge CLK);
	#5;
	a    = addr[6:1];
	rw_n = 1'b1;
	cs_n = 1'b0;
	@(posedge CLK);  // Read start
	#5;
	cs_n = 1'b1;
	@(posedge CLK);  // Output regs land here
	#5;
	data = do_q;
endtask

task automatic wait_sf_clear(input string name);
	logic [7:0] sf;
	logic [7:0] echo;
	int         polls;
	sf    = 8'h01;
	polls = 0;
	while (sf[0] && polls < SF_POLL_LIMIT) begin
		bus_read(smpc_pkg::ADDR_SF, sf);
		read_slot(31, echo);  // Collides with sequencer writes
		polls++;
	end
	if (sf[0]) begin
		errors++;
		$display("%s: SF still set after %0d polls, the command never finished", name, polls);
		finish_run();
	end
endtask

task automatic run_cmd(input smpc_pkg::smpc_cmd_e cmd, input string name);
	bus_write(smpc_pkg::ADDR_SF, 8'h01);
	bus_write(smpc_pkg::ADDR_COMREG, cmd);
	cmds++;
	wait_sf_clear(name);
endtask

task automatic write_ireg(input int idx, input logic [7:0] val);
	bus_write(7'(int'(smpc_pkg::ADDR_IREG0) + 2 * idx), val);
endtask

task automatic read_slot(input int slot, output logic [7:0] data);
	bus_read(7'(int'(smpc_pkg::ADDR_OREG_FIRST) + 2 * slot), data);
endtask

`endif

/* dv/smpc_tb.sv */
`timescale 1ns/1ps

module smpc_tb;

	localparam int SEC_DIV = 1024;  // Long enough that an INTBACK spans under a second
	localparam int SF_POLL_LIMIT = 1000;
	localparam logic [3:0] AREA = 4'h5;

	logic                  CLK = 1'b0;
	logic                  RST_N;
	logic                  CE;
	logic                  MRES_N;
	logic                  TIME_SET;
	logic [3:0]            ac;
	logic [5:0]            a;
	logic [7:0]            di;
	logic                  cs_n;
	logic                  rw_n;
	logic [7:0]            do_q;
	smpc_pkg::smpc_lines_t lines;

	logic [31:0]           lfsr = 32'h83fd064a;
	int                    errors = 0;
	int                    cmds = 0;
	int                    mirq_low_cnt = 0;
	logic [7:0]            oreg_img [32];
	smpc_pkg::smpc_lines_t exp_lines;
	int                    order [8];

	// Columns are command, line values it sets, lines it touches and test name
	// Line bit order is mshres_n mshnmi_n sshres_n sshnmi_n sndres_n cdres_n mirq_n
	smpc_pkg::smpc_cmd_e tbl_cmd [8] = '{smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON,
		smpc_pkg::CMD_SSHOFF, smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF,
		smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF, smpc_pkg::CMD_NMIREQ};
	smpc_pkg::smpc_lines_t tbl_val [8] = '{7'b1100000, 7'b0011000, 7'b0001000, 7'b0000100,
		7'b0000000, 7'b0000010, 7'b0000000, 7'b0100000};
	smpc_pkg::smpc_lines_t tbl_mask [8] = '{7'b1100000, 7'b0011000, 7'b0011000, 7'b0000100,
		7'b0000100, 7'b0000010, 7'b0000010, 7'b0100000};
	string tbl_name [8] = '{"mshon", "sshon", "sshoff", "sndon", "sndoff", "cdon", "cdoff",
		"nmireq"};

	smpc_top #(.SEC_DIV(SEC_DIV)) u_dut (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .MRES_N(MRES_N), .TIME_SET(TIME_SET), .ac(ac),
		.a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n), .do_q(do_q), .lines(lines)
	);

	always #20 CLK = ~CLK;

	always @(negedge CLK) begin
		if (!lines.mirq_n)
			mirq_low_cnt <= mirq_low_cnt + 1;
	end

	`include "smpc_tb_tasks.svh"

	task automatic report_mismatch(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		errors++;
		$display("CHECK FAILED %s: expected %02h, actual %02h", name, expected, actual);
	endtask

	task automatic finish_run();
		$display("commands run %0d, errors %0d", cmds, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic set_time(input logic [15:0] year, input logic [7:0] daymon,
			input logic [7:0] days, input logic [7:0] hour, input logic [7:0] mins,
			input logic [7:0] secs);
		write_ireg(0, year[15:8]);
		write_ireg(1, year[7:0]);
		write_ireg(2, daymon);
		write_ireg(3, days);
		write_ireg(4, hour);
		write_ireg(5, mins);
		write_ireg(6, secs);
		run_cmd(smpc_pkg::CMD_SETTIME, "settime");
	endtask

	// Status-only INTBACK followed by a fetch of slots 0..15 and the echo slot
	task automatic run_intback(input string name);
		logic [7:0] v;
		write_ireg(0, 8'h01);
		write_ireg(2, 8'hF0);
		run_cmd(smpc_pkg::CMD_INTBACK, name);
		for (int s = 0; s <= 15; s++) begin
			read_slot(s, v);
			oreg_img[s] = v;
		end
		read_slot(31, v);
		oreg_img[31] = v;
	endtask

	task automatic rollover(input string name, input logic [15:0] year,
			input logic [7:0] daymon, input logic [7:0] days, input logic [15:0] exp_year,
			input logic [3:0] exp_month);
		set_time(year, daymon, days, 8'h23, 8'h59, 8'h59);
		repeat (3 * SEC_DIV) @(posedge CLK);
		run_intback(name);
		if (oreg_img[1] !== exp_year[15:8])
			report_mismatch({name, " year high"}, exp_year[15:8], oreg_img[1]);
		if (oreg_img[2] !== exp_year[7:0])
			report_mismatch({name, " year low"}, exp_year[7:0], oreg_img[2]);
		if (oreg_img[3][3:0] !== exp_month)
			report_mismatch({name, " month"}, {4'h0, exp_month}, {4'h0, oreg_img[3][3:0]});
		if (oreg_img[4] !== 8'h01)
			report_mismatch({name, " days"}, 8'h01, oreg_img[4]);
		if (oreg_img[5] !== 8'h00)
			report_mismatch({name, " hour"}, 8'h00, oreg_img[5]);
		if (oreg_img[6] !== 8'h00)
			report_mismatch({name, " min"}, 8'h00, oreg_img[6]);
		if (oreg_img[7] < 8'h01 || oreg_img[7] > 8'h09)
			report_mismatch({name, " sec in 01..09"}, 8'h01, oreg_img[7]);
	endtask

	initial begin
		int         j;
		int         k;
		int         tmp;
		int         mon;
		int         wday;
		int         secs;
		int         low_before;
		logic [7:0] v;
		logic [7:0] tv [7];
		RST_N    = 1'b0;
		CE       = 1'b1;
		MRES_N   = 1'b1;
		TIME_SET = 1'b0;
		ac       = AREA;
		a        = '0;
		di       = '0;
		cs_n     = 1'b1;
		rw_n     = 1'b1;
		repeat (10) @(posedge CLK);
		#5;
		RST_N = 1'b1;
		@(posedge CLK);
		#5;
		if ({1'b0, lines} !== 8'h01)
			report_mismatch("lines after reset", 8'h01, {1'b0, lines});
		MRES_N = 1'b0;
		@(posedge CLK);
		#5;
		MRES_N    = 1'b1;
		exp_lines = 7'b1101011;
		if (lines !== exp_lines)
			report_mismatch("lines after MRES_N", {1'b0, exp_lines}, {1'b0, lines});
		bus_read(smpc_pkg::ADDR_SF, v);
		if (v !== 8'h00)
			report_mismatch("SF after MRES_N", 8'h00, v);

		// Power commands in LFSR order
		for (int i = 0; i < 8; i++)
			order[i] = i;
		for (int i = 7; i > 0; i--) begin
			j        = int'(rand_bits(3)) % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int n = 0; n < 8; n++) begin
			k = order[n];
			run_cmd(tbl_cmd[k], tbl_name[k]);
			exp_lines = (exp_lines & ~tbl_mask[k]) | (tbl_val[k] & tbl_mask[k]);
			if (lines !== exp_lines)
				report_mismatch(tbl_name[k], {1'b0, exp_lines}, {1'b0, lines});
			read_slot(31, v);
			if (v !== tbl_cmd[k])
				report_mismatch({tbl_name[k], " echo"}, tbl_cmd[k], v);
		end

		run_cmd(smpc_pkg::CMD_RESENAB, "resenab");
		low_before = mirq_low_cnt;
		run_intback("intback resenab");
		if (oreg_img[0] !== 8'h00)
			report_mismatch("intback status resenab", 8'h00, oreg_img[0]);
		bus_read(smpc_pkg::ADDR_SR, v);
		if (v !== 8'h4F)
			report_mismatch("intback SR", 8'h4F, v);
		if (mirq_low_cnt == low_before) begin
			errors++;
			$display("intback resenab: MIRQ_N was never seen low");
		end
		if (oreg_img[9] !== {4'h0, AREA})
			report_mismatch("intback area code", {4'h0, AREA}, oreg_img[9]);
		if (oreg_img[10] !== {1'b0, ~exp_lines})
			report_mismatch("intback line state", {1'b0, ~exp_lines}, oreg_img[10]);
		for (int s = 8; s <= 15; s++) begin
			if (s != 9 && s != 10 && oreg_img[s] !== 8'h00)
				report_mismatch($sformatf("intback slot %0d", s), 8'h00, oreg_img[s]);
		end
		if (oreg_img[31] !== 8'h10)
			report_mismatch("intback echo", 8'h10, oreg_img[31]);
		run_cmd(smpc_pkg::CMD_RESDISA, "resdisa");
		run_intback("intback resdisa");
		if (oreg_img[0] !== 8'h40)
			report_mismatch("intback status resdisa", 8'h40, oreg_img[0]);

		for (int r = 0; r < 2; r++) begin
			mon   = 1 + int'(rand_bits(4)) % 12;
			wday  = int'(rand_bits(3)) % 7;
			tv[0] = to_bcd(19 + int'(rand_bits(1)));
			tv[1] = to_bcd(int'(rand_bits(7)) % 100);
			tv[2] = 8'(wday * 16 + mon);
			tv[3] = to_bcd(1 + int'(rand_bits(5)) % 28);
			tv[4] = to_bcd(int'(rand_bits(5)) % 24);
			tv[5] = to_bcd(int'(rand_bits(6)) % 60);
			tv[6] = to_bcd(int'(rand_bits(6)) % 58);  // No minute carry within two steps
			set_time({tv[0], tv[1]}, tv[2], tv[3], tv[4], tv[5], tv[6]);
			run_intback("intback after settime");
			for (int i = 0; i < 6; i++) begin
				if (oreg_img[i + 1] !== tv[i])
					report_mismatch("settime readback", tv[i], oreg_img[i + 1]);
			end
			secs = bcd_to_int(oreg_img[7]) - bcd_to_int(tv[6]);
			if (secs < 0 || secs > 2)
				report_mismatch("settime sec within two steps", tv[6], oreg_img[7]);
			if (oreg_img[0] !== 8'hC0)
				report_mismatch("settime status", 8'hC0, oreg_img[0]);
		end

		rollover("new year rollover", 16'h1999, 8'h1C, 8'h31, 16'h2000, 4'd1);
		rollover("february rollover", 16'h2023, 8'h22, 8'h28, 16'h2023, 4'd3);

		finish_run();
	end

endmodule

/* sources.f */
+incdir+dv
src/smpc_pkg.sv
src/smpc_host_regs.sv
src/smpc_cmd_seq.sv
src/smpc_rtc.sv
src/smpc_oreg_arb.sv
src/smpc_top.sv
dv/smpc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := smpc_tb
FILELIST  := sources.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
